//--- Makefile
# Verilator build and run of the address generator testbench

VERILATOR ?= verilator
TOP       ?= tb_addr_gen
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
src/addr_gen_pkg.sv
src/req_sequencer.sv
src/burst_planner.sv
src/ls_cmd_fifo.sv
src/addr_gen_top.sv
verification/addr_gen_checker.sv
verification/tb_addr_gen.sv

//--- src/addr_gen_pkg.sv
`default_nettype none

package addr_gen_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////////////////////////

  // Byte address on the memory bus
  typedef logic [31:0] addr_t;
  // Vector length in elements
  typedef logic [15:0] vl_t;
  // Signed byte distance between two strided elements
  typedef logic signed [31:0] stride_t;

  // Page size is 4 KiB, bursts never cross it
  localparam int unsigned PageBits = 12;
  // Longest incremental burst in bus words
  localparam int unsigned MaxBurstBeats = 256;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Element width, value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  // Vector memory instruction kinds
  typedef enum logic [1:0] {
    OP_UNIT_LOAD     = 2'd0,
    OP_UNIT_STORE    = 2'd1,
    OP_STRIDED_LOAD  = 2'd2,
    OP_STRIDED_STORE = 2'd3
  } mem_op_e;

  //////////////////////////////////////////////////////////////////////
  // Payload structs
  //////////////////////////////////////////////////////////////////////

  // Incoming instruction
  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    vl_t     vl;
    stride_t stride;
    ew_e     ew;
  } mem_req_t;

  // Work item from the sequencer to the burst planner
  typedef struct packed {
    addr_t   addr;
    vl_t     vl;
    stride_t stride;
    ew_e     ew;
    logic    is_load;
    // Unit-stride jobs become incremental bursts
    logic    is_burst;
  } job_t;

  // AR/AW channel payload
  typedef struct packed {
    addr_t      addr;
    // Beats minus one
    logic [7:0] len;
    // log2 of bytes per beat
    logic [2:0] size;
  } ax_req_t;

  // Command queue entry for the load/store units
  typedef struct packed {
    ax_req_t ax;
    logic    is_load;
  } ls_cmd_t;

endpackage

`default_nettype wire

//--- src/addr_gen_top.sv
`timescale 1ns/100ps
`default_nettype none

module addr_gen_top #(
  parameter int unsigned AxiDataWidth  = 64,
  parameter int unsigned CmdQueueDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction interface
  input  addr_gen_pkg::mem_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   ack_o,
  output logic                   error_o,
  // Read address channel
  output addr_gen_pkg::ax_req_t  ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  // Write address channel
  output addr_gen_pkg::ax_req_t  aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  // Commands to the load/store units
  output addr_gen_pkg::ls_cmd_t  cmd_o,
  output logic                   cmd_valid_o,
  input  logic                   ldu_ready_i,
  input  logic                   stu_ready_i
);

  import addr_gen_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Sequencer to planner
  //////////////////////////////////////////////////////////////////////

  job_t job;
  logic job_valid;
  logic job_done;

  // Planner to command queue
  ls_cmd_t cmd_data;
  logic    cmd_push;
  logic    cmd_full;
  logic    cmd_empty;
  logic    head_is_load;

  req_sequencer u_req_sequencer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .ack_o      (ack_o),
    .error_o    (error_o),
    .job_o      (job),
    .job_valid_o(job_valid),
    .job_done_i (job_done)
  );

  burst_planner #(
    .AxiDataWidth(AxiDataWidth)
  ) u_burst_planner (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .job_i         (job),
    .job_valid_i   (job_valid),
    .job_done_o    (job_done),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .cmd_push_o    (cmd_push),
    .cmd_data_o    (cmd_data),
    .cmd_full_i    (cmd_full),
    .cmd_empty_i   (cmd_empty),
    .head_is_load_i(head_is_load)
  );

  // Head direction feeds back for AR/AW ordering
  ls_cmd_fifo #(
    .CmdQueueDepth(CmdQueueDepth)
  ) u_ls_cmd_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (cmd_push),
    .data_i        (cmd_data),
    .full_o        (cmd_full),
    .empty_o       (cmd_empty),
    .head_is_load_o(head_is_load),
    .pop_ldu_i     (ldu_ready_i),
    .pop_stu_i     (stu_ready_i),
    .data_o        (cmd_o),
    .valid_o       (cmd_valid_o)
  );

endmodule

`default_nettype wire

//--- src/burst_planner.sv
`timescale 1ns/100ps
`default_nettype none

module burst_planner #(
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Job from the sequencer
  input  addr_gen_pkg::job_t    job_i,
  input  logic                  job_valid_i,
  output logic                  job_done_o,
  // Address channels
  output addr_gen_pkg::ax_req_t ar_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addr_gen_pkg::ax_req_t aw_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  // Command queue
  output logic                  cmd_push_o,
  output addr_gen_pkg::ls_cmd_t cmd_data_o,
  input  logic                  cmd_full_i,
  input  logic                  cmd_empty_i,
  input  logic                  head_is_load_i
);

  import addr_gen_pkg::*;

  localparam int unsigned BusBytes    = AxiDataWidth / 8;
  localparam int unsigned BusBytesLog = $clog2(BusBytes);

  typedef enum logic [1:0] {
    PLAN_IDLE,
    PLAN_ISSUE,
    PLAN_DONE_WAIT
  } plan_state_e;

  plan_state_e state_q, state_d;

  // Job progress
  addr_t   cur_addr_q;
  vl_t     rem_q, rem_next;
  stride_t stride_q;
  ew_e     ew_q;
  logic    is_load_q;
  logic    is_burst_q;

  // Bounds of the pending burst
  addr_t start_al_q, end_q, next_q;
  addr_t start_al_d, end_d, next_d;

  // Inputs to the bound calculation
  addr_t bound_addr;
  vl_t   bound_rem;
  ew_e   bound_ew;

  addr_t   consumed;
  addr_t   addr_next;
  ax_req_t ax_req;
  logic    order_ok;
  logic    issue;
  logic    ax_ready;
  logic    xfer;
  logic    take_job;

  function automatic addr_t align_bus(addr_t addr);
    return addr & ~addr_t'(BusBytes - 1);
  endfunction

  // Last byte of a burst from addr, smallest of data, page and 256-word limits
  function automatic addr_t burst_end(addr_t addr, vl_t rem, ew_e ew);
    addr_t data_end;
    addr_t page_end;
    addr_t win_end;
    addr_t last;
    data_end = align_bus(addr + (addr_t'(rem) << ew) - addr_t'(1)) + addr_t'(BusBytes - 1);
    page_end = {addr[$bits(addr_t)-1:PageBits], {PageBits{1'b1}}};
    win_end  = align_bus(addr) + addr_t'(MaxBurstBeats * BusBytes) - addr_t'(1);
    last     = data_end;
    if (page_end < last) begin
      last = page_end;
    end
    if (win_end < last) begin
      last = win_end;
    end
    return last;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Request payload and ordering
  //////////////////////////////////////////////////////////////////////

  assign ax_req.addr = cur_addr_q;
  // Beat count from the aligned window
  assign ax_req.len  = is_burst_q ? 8'((end_q - start_al_q) >> BusBytesLog) : 8'd0;
  assign ax_req.size = is_burst_q ? 3'(BusBytesLog) : {1'b0, ew_q};

  // Only issue behind commands of the same direction
  assign order_ok = cmd_empty_i || (head_is_load_i == is_load_q);
  assign issue    = (state_q == PLAN_ISSUE) && order_ok && !cmd_full_i;

  assign ar_o       = ax_req;
  assign aw_o       = ax_req;
  assign ar_valid_o = issue && is_load_q;
  assign aw_valid_o = issue && !is_load_q;

  assign ax_ready = is_load_q ? ar_ready_i : aw_ready_i;
  assign xfer     = issue && ax_ready;

  // One command per transfer
  assign cmd_push_o         = xfer;
  assign cmd_data_o.ax      = ax_req;
  assign cmd_data_o.is_load = is_load_q;

  //////////////////////////////////////////////////////////////////////
  // Progress after a transfer
  //////////////////////////////////////////////////////////////////////

  // Elements covered by this request
  assign consumed = is_burst_q ? ((end_q - cur_addr_q + addr_t'(1)) >> ew_q) : addr_t'(1);
  assign rem_next = (addr_t'(rem_q) > consumed) ? vl_t'(addr_t'(rem_q) - consumed) : '0;
  assign addr_next = is_burst_q ? next_q : cur_addr_q + addr_t'(stride_q);

  assign job_done_o = xfer && (rem_next == '0);
  assign take_job   = (state_q == PLAN_IDLE) && job_valid_i;

  // Bounds for either a fresh job or the next burst
  assign bound_addr = take_job ? job_i.addr : addr_next;
  assign bound_rem  = take_job ? job_i.vl : rem_next;
  assign bound_ew   = take_job ? job_i.ew : ew_q;

  assign start_al_d = align_bus(bound_addr);
  assign end_d      = burst_end(bound_addr, bound_rem, bound_ew);
  assign next_d     = end_d + addr_t'(1);

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      PLAN_IDLE: begin
        if (job_valid_i) begin
          state_d = PLAN_ISSUE;
        end
      end
      PLAN_ISSUE: begin
        if (job_done_o) begin
          state_d = PLAN_DONE_WAIT;
        end
      end
      // Sequencer drops the job valid after its ack
      PLAN_DONE_WAIT: begin
        if (!job_valid_i) begin
          state_d = PLAN_IDLE;
        end
      end
      default: state_d = PLAN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PLAN_IDLE;
      rem_q   <= '0;
    end else begin
      state_q <= state_d;
      if (take_job) begin
        rem_q <= job_i.vl;
      end else if (xfer) begin
        rem_q <= rem_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_job) begin
      cur_addr_q <= job_i.addr;
      stride_q   <= job_i.stride;
      ew_q       <= job_i.ew;
      is_load_q  <= job_i.is_load;
      is_burst_q <= job_i.is_burst;
    end else if (xfer) begin
      cur_addr_q <= addr_next;
    end
    if (take_job || xfer) begin
      start_al_q <= start_al_d;
      end_q      <= end_d;
      next_q     <= next_d;
    end
  end

endmodule

`default_nettype wire

//--- src/ls_cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module ls_cmd_fifo #(
  parameter int unsigned CmdQueueDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Producer side
  input  logic                  push_i,
  input  addr_gen_pkg::ls_cmd_t data_i,
  output logic                  full_o,
  output logic                  empty_o,
  output logic                  head_is_load_o,
  // Load and store units
  input  logic                  pop_ldu_i,
  input  logic                  pop_stu_i,
  output addr_gen_pkg::ls_cmd_t data_o,
  output logic                  valid_o
);

  import addr_gen_pkg::*;

  localparam int unsigned PtrWidth = (CmdQueueDepth > 1) ? $clog2(CmdQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(CmdQueueDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  ls_cmd_t mem_q [CmdQueueDepth];
  ptr_t    rd_ptr_q, wr_ptr_q;
  cnt_t    count_q;
  logic    do_push, do_pop;

  // Wrap at the depth, works for any depth
  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(CmdQueueDepth - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign full_o  = (count_q == cnt_t'(CmdQueueDepth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  // Either unit drains the head
  assign do_pop  = !empty_o && (pop_ldu_i || pop_stu_i);

  assign data_o         = mem_q[rd_ptr_q];
  assign valid_o        = !empty_o;
  assign head_is_load_o = mem_q[rd_ptr_q].is_load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Fill level, unchanged on push with pop
      if (do_push && !do_pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- src/req_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module req_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction source
  input  addr_gen_pkg::mem_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   ack_o,
  output logic                   error_o,
  // Burst planner side
  output addr_gen_pkg::job_t     job_o,
  output logic                   job_valid_o,
  input  logic                   job_done_i
);

  import addr_gen_pkg::*;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_CHECK,
    SEQ_BUSY
  } seq_state_e;

  seq_state_e state_q, state_d;

  // Instruction held for the whole job
  mem_req_t req_q;

  logic misaligned;
  logic empty_job;

  // Base must be a multiple of the element size
  function automatic logic is_misaligned(addr_t addr, ew_e ew);
    addr_t mask;
    mask = (addr_t'(1) << ew) - addr_t'(1);
    return |(addr & mask);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign misaligned = is_misaligned(req_q.addr, req_q.ew);
  // Nothing to move, answer without a job
  assign empty_job  = (req_q.vl == '0);

  assign job_o.addr     = req_q.addr;
  assign job_o.vl       = req_q.vl;
  assign job_o.stride   = req_q.stride;
  assign job_o.ew       = req_q.ew;
  assign job_o.is_load  = (req_q.op inside {OP_UNIT_LOAD, OP_STRIDED_LOAD});
  assign job_o.is_burst = (req_q.op inside {OP_UNIT_LOAD, OP_UNIT_STORE});

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    ack_o       = 1'b0;
    error_o     = 1'b0;
    job_valid_o = 1'b0;

    case (state_q)
      SEQ_IDLE: begin
        if (req_valid_i) begin
          state_d = SEQ_CHECK;
        end
      end
      SEQ_CHECK: begin
        if (misaligned) begin
          // Error ack, no bus traffic at all
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = SEQ_IDLE;
        end else if (empty_job) begin
          ack_o   = 1'b1;
          state_d = SEQ_IDLE;
        end else begin
          // Planner samples the job at the end of this cycle
          job_valid_o = 1'b1;
          state_d     = SEQ_BUSY;
        end
      end
      SEQ_BUSY: begin
        job_valid_o = 1'b1;
        // Ack lines up with the last transfer
        if (job_done_i) begin
          ack_o   = 1'b1;
          state_d = SEQ_IDLE;
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the instruction on acceptance
  always_ff @(posedge clk_i) begin
    if (state_q == SEQ_IDLE && req_valid_i) begin
      req_q <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- verification/addr_gen_checker.sv
`timescale 1ns/100ps
`default_nettype none

module addr_gen_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  // Instruction handshake
  input logic                  ack_i,
  input logic                  error_i,
  // Read address channel
  input addr_gen_pkg::ax_req_t ar_i,
  input logic                  ar_valid_i,
  input logic                  ar_ready_i,
  // Write address channel
  input addr_gen_pkg::ax_req_t aw_i,
  input logic                  aw_valid_i,
  input logic                  aw_ready_i
);

  import addr_gen_pkg::*;

  addr_t ar_last;
  addr_t aw_last;

  // Last byte touched by a request, counted from its size-aligned start
  function automatic addr_t last_byte(ax_req_t ax);
    addr_t base;
    base = ax.addr & ~((addr_t'(1) << ax.size) - addr_t'(1));
    return base + ((addr_t'(ax.len) + addr_t'(1)) << ax.size) - addr_t'(1);
  endfunction

  assign ar_last = last_byte(ar_i);
  assign aw_last = last_byte(aw_i);

  //////////////////////////////////////////////////////////////////////
  // Channel handshake
  //////////////////////////////////////////////////////////////////////

  // A stalled request keeps valid and payload
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else $error("AR request dropped or changed while stalled");

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else $error("AW request dropped or changed while stalled");

  // One direction at a time
  ar_aw_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_i && aw_valid_i))
    else $error("AR and AW valid in the same cycle");

  //////////////////////////////////////////////////////////////////////
  // Burst bounds and ack
  //////////////////////////////////////////////////////////////////////

  ar_in_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i |-> ar_last[31:PageBits] == ar_i.addr[31:PageBits])
    else $error("AR burst crosses a 4 KiB page");

  aw_in_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i |-> aw_last[31:PageBits] == aw_i.addr[31:PageBits])
    else $error("AW burst crosses a 4 KiB page");

  // Error only rides on an ack
  error_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_i |-> ack_i)
    else $error("error_o high without ack_o");

endmodule

`default_nettype wire

//--- verification/tb_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_addr_gen;

  import addr_gen_pkg::*;

  localparam int unsigned     AxiDataWidth = 64;
  localparam int unsigned     BusLog       = $clog2(AxiDataWidth / 8);
  localparam longint unsigned BusBytes     = 64'(AxiDataWidth / 8);
  localparam longint unsigned PageSize     = 64'd1 << PageBits;
  localparam longint unsigned MaxBeats     = 64'(MaxBurstBeats);
  localparam int              WaitCycles   = 2000;

  // DUT inputs, all start at a known value
  logic     clk_i = 1'b0;
  logic     rst_ni = 1'b0;
  mem_req_t req_i = '0;
  logic     req_valid_i = 1'b0;
  logic     ar_ready_i = 1'b0;
  logic     aw_ready_i = 1'b0;
  logic     ldu_ready_i = 1'b0;
  logic     stu_ready_i = 1'b0;

  // DUT outputs
  logic     ack_o;
  logic     error_o;
  ax_req_t  ar_o;
  logic     ar_valid_o;
  ax_req_t  aw_o;
  logic     aw_valid_o;
  ls_cmd_t  cmd_o;
  logic     cmd_valid_o;

  // Responder modes
  logic     rand_ready = 1'b0;
  logic     hold_units = 1'b0;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned order_errors = 0;
  int unsigned loads_pushed = 0;
  int unsigned loads_popped = 0;

  // Observed transfers, only the monitor appends
  ax_req_t ar_q[$];
  ax_req_t aw_q[$];
  ls_cmd_t cmd_q[$];
  int      ar_base;
  int      aw_base;
  int      cmd_base;

  // Expected sequences from the reference model
  ax_req_t exp_ar[$];
  ax_req_t exp_aw[$];
  ls_cmd_t exp_cmd[$];

  addr_gen_top #(
    .AxiDataWidth (AxiDataWidth),
    .CmdQueueDepth(4)
  ) u_addr_gen_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_valid_i(req_valid_i),
    .ack_o      (ack_o),
    .error_o    (error_o),
    .ar_o       (ar_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .aw_o       (aw_o),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .cmd_o      (cmd_o),
    .cmd_valid_o(cmd_valid_o),
    .ldu_ready_i(ldu_ready_i),
    .stu_ready_i(stu_ready_i)
  );

  bind addr_gen_top addr_gen_checker u_addr_gen_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ack_i     (ack_o),
    .error_i   (error_o),
    .ar_i      (ar_o),
    .ar_valid_i(ar_valid_o),
    .ar_ready_i(ar_ready_i),
    .aw_i      (aw_o),
    .aw_valid_i(aw_valid_o),
    .aw_ready_i(aw_ready_i)
  );

  initial begin
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus responder and monitor
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(43));
    forever begin
      @(posedge clk_i);
      if (rand_ready) begin
        ar_ready_i <= ($urandom % 3) != 0;
        aw_ready_i <= ($urandom % 3) != 0;
      end else begin
        ar_ready_i <= 1'b1;
        aw_ready_i <= 1'b1;
      end
      ldu_ready_i <= !hold_units;
      stu_ready_i <= !hold_units;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o && ar_ready_i) begin
        ar_q.push_back(ar_o);
        loads_pushed++;
      end
      if (aw_valid_o && aw_ready_i) begin
        // Pops of this edge are not counted yet
        assert (loads_pushed == loads_popped) else begin
          order_errors++;
          $display("Ordering violation: AW transfer while %0d load commands are queued",
                   loads_pushed - loads_popped);
        end
        aw_q.push_back(aw_o);
      end
      if (cmd_valid_o && (ldu_ready_i || stu_ready_i)) begin
        cmd_q.push_back(cmd_o);
        if (cmd_o.is_load) begin
          loads_popped++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic add_expected(input ax_req_t ax, input logic is_load);
    ls_cmd_t cmd;
    cmd.ax      = ax;
    cmd.is_load = is_load;
    if (is_load) begin
      exp_ar.push_back(ax);
    end else begin
      exp_aw.push_back(ax);
    end
    exp_cmd.push_back(cmd);
  endtask

  // Bursts bounded by data end, page end and the 256-word window
  task automatic model_unit(input addr_t addr, input vl_t vl, input ew_e ew, input logic is_load);
    longint unsigned a;
    longint unsigned rem;
    longint unsigned last;
    longint unsigned page_last;
    longint unsigned first_word;
    longint unsigned used;
    ax_req_t         ax;
    a   = 64'(addr);
    rem = 64'(vl);
    while (rem != 64'd0) begin
      first_word = a / BusBytes;
      last       = ((a + (rem << ew) - 64'd1) / BusBytes) * BusBytes + BusBytes - 64'd1;
      page_last  = (a / PageSize) * PageSize + PageSize - 64'd1;
      if (page_last < last) begin
        last = page_last;
      end
      if (last / BusBytes - first_word + 64'd1 > MaxBeats) begin
        last = (first_word + MaxBeats) * BusBytes - 64'd1;
      end
      ax.addr = addr_t'(a);
      ax.len  = 8'(last / BusBytes - first_word);
      ax.size = 3'(BusLog);
      add_expected(ax, is_load);
      used = (last - a + 64'd1) >> ew;
      rem  = (used >= rem) ? 64'd0 : rem - used;
      a    = last + 64'd1;
    end
  endtask

  task automatic model_strided(input mem_req_t req, input logic is_load);
    ax_req_t ax;
    for (int k = 0; k < int'(req.vl); k++) begin
      ax.addr = req.addr + addr_t'(k) * addr_t'(req.stride);
      ax.len  = 8'd0;
      ax.size = {1'b0, req.ew};
      add_expected(ax, is_load);
    end
  endtask

  // Misaligned base gives no requests at all
  task automatic model_req(input mem_req_t req);
    logic is_load;
    is_load = (req.op == OP_UNIT_LOAD) || (req.op == OP_STRIDED_LOAD);
    if ((req.addr & ((32'd1 << req.ew) - 32'd1)) == 32'd0) begin
      if (req.op == OP_UNIT_LOAD || req.op == OP_UNIT_STORE) begin
        model_unit(req.addr, req.vl, req.ew, is_load);
      end else begin
        model_strided(req, is_load);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////////////////////////

  function automatic mem_req_t make_req(mem_op_e op, addr_t addr, vl_t vl, stride_t stride,
                                        ew_e ew);
    mem_req_t req;
    req.op     = op;
    req.addr   = addr;
    req.vl     = vl;
    req.stride = stride;
    req.ew     = ew;
    return req;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
    end
  endtask

  task automatic compare_ax(input string name, input ax_req_t got, input ax_req_t exp);
    check_value({name, ".addr"}, got.addr, exp.addr);
    check_value({name, ".len"}, 32'(got.len), 32'(exp.len));
    check_value({name, ".size"}, 32'(got.size), 32'(exp.size));
  endtask

  // Clear the model and mark where this test's transfers begin
  task automatic begin_test();
    exp_ar.delete();
    exp_aw.delete();
    exp_cmd.delete();
    ar_base  = ar_q.size();
    aw_base  = aw_q.size();
    cmd_base = cmd_q.size();
  endtask

  task automatic start_req(input mem_req_t req);
    @(posedge clk_i);
    req_i       <= req;
    req_valid_i <= 1'b1;
  endtask

  task automatic wait_ack(input string name, output logic err);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    err  = 1'b0;
    while (!seen && n < WaitCycles) begin
      @(posedge clk_i);
      n++;
      if (ack_o) begin
        seen = 1'b1;
        err  = error_o;
      end
    end
    // Source drops the instruction right after its ack
    req_valid_i <= 1'b0;
    assert (seen) else begin
      errors++;
      $display("Timeout: no ack within %0d cycles in %s", WaitCycles, name);
    end
  endtask

  // At least one edge, so a push in the ack cycle shows up first
  task automatic wait_drain(input string name);
    int   n;
    logic busy;
    n    = 0;
    busy = 1'b1;
    while (busy && n < WaitCycles) begin
      @(posedge clk_i);
      n++;
      busy = cmd_valid_o;
    end
    assert (!busy) else begin
      errors++;
      $display("Timeout: command queue not drained within %0d cycles in %s", WaitCycles, name);
    end
  endtask

  task automatic issue_and_ack(input string name, input mem_req_t req, input logic exp_err);
    logic err;
    start_req(req);
    wait_ack(name, err);
    check_value({name, " error_o"}, 32'(err), 32'(exp_err));
  endtask

  task automatic compare_observed(input string name);
    int n_ar;
    int n_aw;
    int n_cmd;
    n_ar  = ar_q.size() - ar_base;
    n_aw  = aw_q.size() - aw_base;
    n_cmd = cmd_q.size() - cmd_base;
    check_value({name, " ar_o count"}, 32'(n_ar), 32'(exp_ar.size()));
    check_value({name, " aw_o count"}, 32'(n_aw), 32'(exp_aw.size()));
    check_value({name, " cmd_o count"}, 32'(n_cmd), 32'(exp_cmd.size()));
    for (int i = 0; i < n_ar && i < exp_ar.size(); i++) begin
      compare_ax($sformatf("%s ar_o[%0d]", name, i), ar_q[ar_base + i], exp_ar[i]);
    end
    for (int i = 0; i < n_aw && i < exp_aw.size(); i++) begin
      compare_ax($sformatf("%s aw_o[%0d]", name, i), aw_q[aw_base + i], exp_aw[i]);
    end
    for (int i = 0; i < n_cmd && i < exp_cmd.size(); i++) begin
      compare_ax($sformatf("%s cmd_o[%0d].ax", name, i), cmd_q[cmd_base + i].ax,
                 exp_cmd[i].ax);
      check_value($sformatf("%s cmd_o[%0d].is_load", name, i),
                  32'(cmd_q[cmd_base + i].is_load), 32'(exp_cmd[i].is_load));
    end
  endtask

  // Model, drive, wait for the ack and the drained queue, then compare
  task automatic run_single(input string name, input mem_req_t req, input logic exp_err);
    begin_test();
    model_req(req);
    issue_and_ack(name, req, exp_err);
    wait_drain(name);
    compare_observed(name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic unit_load_one_page();
    run_single("unit_load_one_page", make_req(OP_UNIT_LOAD, 32'h1000, 16'd10, 32'sd0, EW32),
               1'b0);
  endtask

  task automatic unit_store_page_cross();
    run_single("unit_store_page_cross",
               make_req(OP_UNIT_STORE, 32'h1FF0, 16'd8, 32'sd0, EW64), 1'b0);
  endtask

  // 4096 bytes, two full 256-beat bursts
  task automatic unit_load_long();
    run_single("unit_load_long", make_req(OP_UNIT_LOAD, 32'h0, 16'd1024, 32'sd0, EW32), 1'b0);
  endtask

  task automatic strided_store();
    run_single("strided_store", make_req(OP_STRIDED_STORE, 32'h300, 16'd5, 32'sh24, EW16),
               1'b0);
  endtask

  task automatic misaligned_base();
    run_single("misaligned_base", make_req(OP_UNIT_LOAD, 32'h1002, 16'd4, 32'sd0, EW32), 1'b1);
  endtask

  // Loads sit in the queue while the units stall, the store must wait behind them
  task automatic backpressure_ordering();
    mem_req_t ld;
    mem_req_t st;
    logic     err;
    begin_test();
    ld = make_req(OP_STRIDED_LOAD, 32'h4000, 16'd3, 32'sh40, EW32);
    st = make_req(OP_UNIT_STORE, 32'h5FF8, 16'd8, 32'sd0, EW64);
    model_req(ld);
    model_req(st);
    hold_units <= 1'b1;
    rand_ready <= 1'b1;
    issue_and_ack("backpressure_ordering load", ld, 1'b0);
    start_req(st);
    repeat (12) @(posedge clk_i);
    check_value("backpressure_ordering aw_o count with loads queued",
                32'(aw_q.size() - aw_base), 32'd0);
    hold_units <= 1'b0;
    wait_ack("backpressure_ordering store", err);
    check_value("backpressure_ordering store error_o", 32'(err), 32'd0);
    wait_drain("backpressure_ordering");
    rand_ready <= 1'b0;
    compare_observed("backpressure_ordering");
  endtask

  initial begin
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    unit_load_one_page();
    unit_store_page_cross();
    unit_load_long();
    strided_store();
    misaligned_base();
    backpressure_ordering();

    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, value errors: %0d, ordering errors: %0d", checks, errors,
             order_errors);
    if (errors == 0 && order_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
